/* rtl/cpu_pkg.sv */
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Instruction field positions
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_W   = 3;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int IMM_LSB    = 20;
  localparam int IMM_W      = 12;
  localparam int FUNCT7_LSB = 25;
  localparam int FUNCT7_W   = 7;

  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [FUNCT7_W-1:0] FUNCT7_MULDIV = 7'b0000001;

  typedef enum logic [OPCODE_W-1:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_t;

endpackage

/* rtl/fetch_unit.sv */
module fetch_unit #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     mem_data_valid_i,
  input  logic [cpu_pkg::XLEN-1:0] mem_data_i,
  input  logic                     instr_ready_i,
  output logic                     rd_req_valid_o,
  output logic [ADDR_WIDTH-1:0]    req_address_o,
  output logic                     instr_valid_o,
  output logic [cpu_pkg::XLEN-1:0] instr_o
);

  logic                     started_q;
  logic                     waiting_q;
  logic                     held_valid_q;
  logic [cpu_pkg::XLEN-1:0] held_instr_q;
  logic [ADDR_WIDTH-1:0]    pc_q;

  // New read once running, nothing outstanding and the held word leaves
  assign rd_req_valid_o = started_q & ~waiting_q & (~held_valid_q | instr_ready_i);
  assign req_address_o  = pc_q;
  assign instr_valid_o  = held_valid_q;
  assign instr_o        = held_instr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      started_q    <= 1'b0;
      waiting_q    <= 1'b0;
      held_valid_q <= 1'b0;
      pc_q         <= '0;
    end else begin
      started_q <= 1'b1;
      if (rd_req_valid_o) begin
        waiting_q <= 1'b1;
        pc_q      <= pc_q + ADDR_WIDTH'(4);
      end else if (mem_data_valid_i) begin
        waiting_q <= 1'b0;
      end
      if (mem_data_valid_i) begin
        held_valid_q <= 1'b1;
      end else if (held_valid_q && instr_ready_i) begin
        held_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_data_valid_i) begin
      held_instr_q <= mem_data_i;
    end
  end

endmodule

/* rtl/decode_unit.sv */
module decode_unit (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           instr_valid_i,
  input  logic [cpu_pkg::XLEN-1:0]       instr_i,
  input  logic [cpu_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [cpu_pkg::XLEN-1:0]       rs2_data_i,
  input  logic                           alu_ready_i,
  input  logic                           wb_en_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd_i,
  output logic                           instr_ready_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic                           alu_valid_o,
  output cpu_pkg::alu_op_t               alu_op_o,
  output logic [cpu_pkg::XLEN-1:0]       alu_a_o,
  output logic [cpu_pkg::XLEN-1:0]       alu_b_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] alu_rd_o,
  output logic                           mul_valid_o,
  output logic [cpu_pkg::XLEN-1:0]       mul_a_o,
  output logic [cpu_pkg::XLEN-1:0]       mul_b_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] mul_rd_o
);

  cpu_pkg::opcode_t                    opcode;
  logic [cpu_pkg::REG_ADDR_W-1:0]      rd;
  logic [cpu_pkg::FUNCT3_W-1:0]        funct3;
  logic [cpu_pkg::FUNCT7_W-1:0]        funct7;
  logic [cpu_pkg::XLEN-1:0]            imm;
  logic                                is_op, is_imm, is_mul, is_alu;
  logic                                writes, hazard;
  logic [cpu_pkg::NUM_REGS-1:0]        pending_q, wb_clear, busy;

  assign opcode = cpu_pkg::opcode_t'(instr_i[cpu_pkg::OPCODE_W-1:0]);
  assign rd     = instr_i[cpu_pkg::RD_LSB +: cpu_pkg::REG_ADDR_W];
  assign funct3 = instr_i[cpu_pkg::FUNCT3_LSB +: cpu_pkg::FUNCT3_W];
  assign funct7 = instr_i[cpu_pkg::FUNCT7_LSB +: cpu_pkg::FUNCT7_W];
  assign rs1_o  = instr_i[cpu_pkg::RS1_LSB +: cpu_pkg::REG_ADDR_W];
  assign rs2_o  = instr_i[cpu_pkg::RS2_LSB +: cpu_pkg::REG_ADDR_W];
  assign imm    = cpu_pkg::XLEN'($signed(instr_i[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W]));

  assign is_op  = (opcode == cpu_pkg::OPC_OP);
  assign is_imm = (opcode == cpu_pkg::OPC_OP_IMM) && (funct3 == 3'b000);
  assign is_mul = is_op && (funct7 == cpu_pkg::FUNCT7_MULDIV) && (funct3 == 3'b000);

  always_comb begin
    alu_op_o = cpu_pkg::ALU_ADD;
    is_alu   = 1'b0;
    if (is_imm) begin
      is_alu = 1'b1;
    end else if (is_op && funct7 == '0) begin
      is_alu = 1'b1;
      case (funct3)
        3'b000:  alu_op_o = cpu_pkg::ALU_ADD;
        3'b001:  alu_op_o = cpu_pkg::ALU_SLL;
        3'b010:  alu_op_o = cpu_pkg::ALU_SLT;
        3'b100:  alu_op_o = cpu_pkg::ALU_XOR;
        3'b101:  alu_op_o = cpu_pkg::ALU_SRL;
        3'b110:  alu_op_o = cpu_pkg::ALU_OR;
        3'b111:  alu_op_o = cpu_pkg::ALU_AND;
        default: is_alu   = 1'b0;
      endcase
    end else if (is_op && funct7 == cpu_pkg::FUNCT7_ALT && funct3 == 3'b000) begin
      is_alu   = 1'b1;
      alu_op_o = cpu_pkg::ALU_SUB;
    end
  end

  // A write landing this cycle is already visible through the register file
  assign wb_clear = wb_en_i ? (cpu_pkg::NUM_REGS'(1) << wb_rd_i) : '0;
  assign busy     = pending_q & ~wb_clear;
  assign hazard   = busy[rd] | busy[rs1_o] | (is_op & busy[rs2_o]);

  // No-ops and writes to x0 are simply dropped
  assign writes        = (is_alu | is_mul) && (rd != '0);
  assign instr_ready_o = ~writes | (~hazard & (is_mul | alu_ready_i));

  assign alu_valid_o = instr_valid_i & writes & ~is_mul & ~hazard;
  assign alu_a_o     = rs1_data_i;
  assign alu_b_o     = is_imm ? imm : rs2_data_i;
  assign alu_rd_o    = rd;
  assign mul_valid_o = instr_valid_i & writes & is_mul & ~hazard;
  assign mul_a_o     = rs1_data_i;
  assign mul_b_o     = rs2_data_i;
  assign mul_rd_o    = rd;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending_q <= '0;
    end else begin
      if (wb_en_i) begin
        pending_q[wb_rd_i] <= 1'b0;
      end
      // Set after clear so a same-cycle issue keeps the bit
      if ((alu_valid_o && alu_ready_i) || mul_valid_o) begin
        pending_q[rd] <= 1'b1;
      end
    end
  end

endmodule

/* rtl/register_file.sv */
module register_file (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           wr_en_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_reg_i,
  input  logic [cpu_pkg::XLEN-1:0]       wr_data_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_reg_a_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_reg_b_i,
  output logic [cpu_pkg::XLEN-1:0]       reg_a_data_o,
  output logic [cpu_pkg::XLEN-1:0]       reg_b_data_o
);

  logic [cpu_pkg::XLEN-1:0] regs_q [cpu_pkg::NUM_REGS];
  logic                     wr_ok;

  assign wr_ok = wr_en_i && (wr_reg_i != '0);

  // Write-through on a same-cycle read
  assign reg_a_data_o = (rd_reg_a_i == '0) ? '0 :
                        (wr_ok && wr_reg_i == rd_reg_a_i) ? wr_data_i : regs_q[rd_reg_a_i];
  assign reg_b_data_o = (rd_reg_b_i == '0) ? '0 :
                        (wr_ok && wr_reg_i == rd_reg_b_i) ? wr_data_i : regs_q[rd_reg_b_i];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      regs_q <= '{default: '0};
    end else if (wr_ok) begin
      regs_q[wr_reg_i] <= wr_data_i;
    end
  end

endmodule

/* rtl/alu_stage.sv */
module alu_stage (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           valid_i,
  input  cpu_pkg::alu_op_t               op_i,
  input  logic [cpu_pkg::XLEN-1:0]       a_i,
  input  logic [cpu_pkg::XLEN-1:0]       b_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                           grant_i,
  output logic                           ready_o,
  output logic                           done_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [cpu_pkg::XLEN-1:0]       result_o
);

  logic                     valid_q;
  cpu_pkg::alu_op_t         op_q;
  logic [cpu_pkg::XLEN-1:0] a_q, b_q;

  // Stuck while a finished result waits for the write port
  assign ready_o = ~valid_q | grant_i;
  assign done_o  = valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      op_q <= op_i;
      a_q  <= a_i;
      b_q  <= b_i;
      rd_o <= rd_i;
    end
  end

  always_comb begin
    case (op_q)
      cpu_pkg::ALU_SUB: result_o = a_q - b_q;
      cpu_pkg::ALU_AND: result_o = a_q & b_q;
      cpu_pkg::ALU_OR:  result_o = a_q | b_q;
      cpu_pkg::ALU_XOR: result_o = a_q ^ b_q;
      cpu_pkg::ALU_SLT: result_o = cpu_pkg::XLEN'($signed(a_q) < $signed(b_q));
      cpu_pkg::ALU_SLL: result_o = a_q << b_q[4:0];
      cpu_pkg::ALU_SRL: result_o = a_q >> b_q[4:0];
      default:          result_o = a_q + b_q;
    endcase
  end

endmodule

/* rtl/mul_pipe.sv */
module mul_pipe #(
  parameter int MUL_DEPTH = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           valid_i,
  input  logic [cpu_pkg::XLEN-1:0]       a_i,
  input  logic [cpu_pkg::XLEN-1:0]       b_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_i,
  output logic                           done_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [cpu_pkg::XLEN-1:0]       result_o
);

  logic [MUL_DEPTH-1:0]           valid_q;
  logic [cpu_pkg::REG_ADDR_W-1:0] rd_q  [MUL_DEPTH];
  logic [cpu_pkg::XLEN-1:0]       res_q [MUL_DEPTH];

  assign done_o   = valid_q[MUL_DEPTH-1];
  assign rd_o     = rd_q[MUL_DEPTH-1];
  assign result_o = res_q[MUL_DEPTH-1];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < MUL_DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Low half of the product, then plain delay stages
  always_ff @(posedge clk_i) begin
    rd_q[0]  <= rd_i;
    res_q[0] <= a_i * b_i;
    for (int i = 1; i < MUL_DEPTH; i++) begin
      rd_q[i]  <= rd_q[i-1];
      res_q[i] <= res_q[i-1];
    end
  end

endmodule

/* rtl/wb_arbiter.sv */
module wb_arbiter (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           mul_done_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] mul_rd_i,
  input  logic [cpu_pkg::XLEN-1:0]       mul_result_i,
  input  logic                           alu_done_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] alu_rd_i,
  input  logic [cpu_pkg::XLEN-1:0]       alu_result_i,
  output logic                           alu_grant_o,
  output logic                           wb_en_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [cpu_pkg::XLEN-1:0]       wb_data_o,
  output logic                           retire_valid_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] retire_reg_o,
  output logic [cpu_pkg::XLEN-1:0]       retire_data_o
);

  // Multiply cannot stall, so it always wins
  assign alu_grant_o = ~mul_done_i;
  assign wb_en_o     = mul_done_i | alu_done_i;
  assign wb_rd_o     = mul_done_i ? mul_rd_i : alu_rd_i;
  assign wb_data_o   = mul_done_i ? mul_result_i : alu_result_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= wb_en_o;
    end
  end

  always_ff @(posedge clk_i) begin
    retire_reg_o  <= wb_rd_o;
    retire_data_o <= wb_data_o;
  end

endmodule

/* rtl/cpu_core.sv */
module cpu_core #(
  parameter int ADDR_WIDTH = 16,
  parameter int MUL_DEPTH  = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           mem_data_valid_i,
  input  logic [cpu_pkg::XLEN-1:0]       mem_data_i,
  output logic                           rd_req_valid_o,
  output logic [ADDR_WIDTH-1:0]          req_address_o,
  output logic                           retire_valid_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] retire_reg_o,
  output logic [cpu_pkg::XLEN-1:0]       retire_data_o
);

  // Fetch to decode
  logic                           instr_valid, instr_ready;
  logic [cpu_pkg::XLEN-1:0]       instr;

  // Register reads
  logic [cpu_pkg::REG_ADDR_W-1:0] rs1, rs2;
  logic [cpu_pkg::XLEN-1:0]       rs1_data, rs2_data;

  // Issue
  logic                           alu_valid, alu_ready, mul_valid;
  cpu_pkg::alu_op_t               alu_op;
  logic [cpu_pkg::XLEN-1:0]       alu_a, alu_b, mul_a, mul_b;
  logic [cpu_pkg::REG_ADDR_W-1:0] alu_rd, mul_rd;

  // Results and write-back
  logic                           alu_done, mul_done, alu_grant, wb_en;
  logic [cpu_pkg::REG_ADDR_W-1:0] alu_rd_q, mul_rd_q, wb_rd;
  logic [cpu_pkg::XLEN-1:0]       alu_result, mul_result, wb_data;

  fetch_unit #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_fetch (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .mem_data_valid_i (mem_data_valid_i),
    .mem_data_i       (mem_data_i),
    .instr_ready_i    (instr_ready),
    .rd_req_valid_o   (rd_req_valid_o),
    .req_address_o    (req_address_o),
    .instr_valid_o    (instr_valid),
    .instr_o          (instr)
  );

  decode_unit u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .alu_ready_i   (alu_ready),
    .wb_en_i       (wb_en),
    .wb_rd_i       (wb_rd),
    .instr_ready_o (instr_ready),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .alu_valid_o   (alu_valid),
    .alu_op_o      (alu_op),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .alu_rd_o      (alu_rd),
    .mul_valid_o   (mul_valid),
    .mul_a_o       (mul_a),
    .mul_b_o       (mul_b),
    .mul_rd_o      (mul_rd)
  );

  register_file u_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (wb_en),
    .wr_reg_i     (wb_rd),
    .wr_data_i    (wb_data),
    .rd_reg_a_i   (rs1),
    .rd_reg_b_i   (rs2),
    .reg_a_data_o (rs1_data),
    .reg_b_data_o (rs2_data)
  );

  alu_stage u_alu (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .valid_i  (alu_valid),
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .rd_i     (alu_rd),
    .grant_i  (alu_grant),
    .ready_o  (alu_ready),
    .done_o   (alu_done),
    .rd_o     (alu_rd_q),
    .result_o (alu_result)
  );

  mul_pipe #(
    .MUL_DEPTH (MUL_DEPTH)
  ) u_mul (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .valid_i  (mul_valid),
    .a_i      (mul_a),
    .b_i      (mul_b),
    .rd_i     (mul_rd),
    .done_o   (mul_done),
    .rd_o     (mul_rd_q),
    .result_o (mul_result)
  );

  wb_arbiter u_wb (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mul_done_i     (mul_done),
    .mul_rd_i       (mul_rd_q),
    .mul_result_i   (mul_result),
    .alu_done_i     (alu_done),
    .alu_rd_i       (alu_rd_q),
    .alu_result_i   (alu_result),
    .alu_grant_o    (alu_grant),
    .wb_en_o        (wb_en),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .retire_valid_o (retire_valid_o),
    .retire_reg_o   (retire_reg_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

/* sim/cpu_checker.sv */
module cpu_checker #(
  parameter int ADDR_WIDTH = 16
) (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           mem_data_valid_i,
  input logic                           rd_req_valid_o,
  input logic [ADDR_WIDTH-1:0]          req_address_o,
  input logic                           retire_valid_o,
  input logic [cpu_pkg::REG_ADDR_W-1:0] retire_reg_o
);

  logic outstanding_q;

  // Tracks the single read in flight on the memory bus
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      outstanding_q <= 1'b0;
    end else if (rd_req_valid_o) begin
      outstanding_q <= 1'b1;
    end else if (mem_data_valid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_i) rd_req_valid_o |-> !outstanding_q)
    else $error("Read request issued while a response is outstanding");

  assert property (@(posedge clk_i) disable iff (!rst_i) retire_valid_o |-> retire_reg_o != '0)
    else $error("Retire reported for register x0");

  assert property (@(posedge clk_i) disable iff (!rst_i)
                   rd_req_valid_o |-> req_address_o[1:0] == 2'b00)
    else $error("Request address is not word aligned");

endmodule

bind cpu_core cpu_checker #(
  .ADDR_WIDTH (ADDR_WIDTH)
) u_checker (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .mem_data_valid_i (mem_data_valid_i),
  .rd_req_valid_o   (rd_req_valid_o),
  .req_address_o    (req_address_o),
  .retire_valid_o   (retire_valid_o),
  .retire_reg_o     (retire_reg_o)
);

/* sim/cpu_tb.sv */
module cpu_tb;

  localparam int          ADDR_WIDTH = 16;
  localparam int          MUL_DEPTH  = 4;
  localparam int          RAND_LEN   = 60;
  localparam int unsigned SEED       = 96813;
  localparam logic [31:0] NOP_WORD   = 32'h00000013;
  localparam logic [6:0]  F7_BASE    = 7'b0000000;
  localparam logic [6:0]  F7_ALT     = cpu_pkg::FUNCT7_ALT;
  localparam logic [6:0]  F7_MUL     = cpu_pkg::FUNCT7_MULDIV;

  logic                           clk_i;
  logic                           rst_i;
  logic                           mem_data_valid_i;
  logic [cpu_pkg::XLEN-1:0]       mem_data_i;
  logic                           rd_req_valid_o;
  logic [ADDR_WIDTH-1:0]          req_address_o;
  logic                           retire_valid_o;
  logic [cpu_pkg::REG_ADDR_W-1:0] retire_reg_o;
  logic [cpu_pkg::XLEN-1:0]       retire_data_o;

  logic [31:0] prog [$];
  logic [4:0]  exp_reg [$];
  logic [31:0] exp_val [$];
  int          exp_idx [$];
  int          dir_len;
  int          cycles;
  int          cycle_limit;
  int          drain_end;
  logic        fetched_all;

  cpu_core #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .MUL_DEPTH  (MUL_DEPTH)
  ) UUT (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .mem_data_valid_i (mem_data_valid_i),
    .mem_data_i       (mem_data_i),
    .rd_req_valid_o   (rd_req_valid_o),
    .req_address_o    (req_address_o),
    .retire_valid_o   (retire_valid_o),
    .retire_reg_o     (retire_reg_o),
    .retire_data_o    (retire_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  task automatic push_op(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                         input int rs1, input int rs2);
    prog.push_back(r_type_word(f7, f3, 5'(rd), 5'(rs1), 5'(rs2)));
  endtask

  task automatic push_addi(input int rd, input int rs1, input int imm);
    prog.push_back(i_type_word(7'b0010011, 3'd0, 5'(rd), 5'(rs1), 12'(imm)));
  endtask

  function automatic logic [31:0] random_word();
    int unsigned kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    kind = $urandom % 10;
    rd   = 5'($urandom % 8);
    rs1  = 5'($urandom % 8);
    rs2  = 5'($urandom % 8);
    imm  = 12'($urandom);
    case (kind)
      0:       return r_type_word(F7_BASE, 3'd0, rd, rs1, rs2);
      1:       return r_type_word(F7_ALT, 3'd0, rd, rs1, rs2);
      2:       return r_type_word(F7_BASE, 3'd7, rd, rs1, rs2);
      3:       return r_type_word(F7_BASE, 3'd6, rd, rs1, rs2);
      4:       return r_type_word(F7_BASE, 3'd4, rd, rs1, rs2);
      5:       return r_type_word(F7_BASE, 3'd2, rd, rs1, rs2);
      6:       return r_type_word(F7_BASE, 3'd1, rd, rs1, rs2);
      7:       return r_type_word(F7_BASE, 3'd5, rd, rs1, rs2);
      8:       return i_type_word(7'b0010011, 3'd0, rd, rs1, imm);
      default: return r_type_word(F7_MUL, 3'd0, rd, rs1, rs2);
    endcase
  endfunction

  // Result layout is {write, rd, value}
  function automatic logic [37:0] reference_write(input logic [31:0] word, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    logic [31:0] val;
    logic        ok;
    opc = word[6:0];
    rd  = word[11:7];
    f3  = word[14:12];
    f7  = word[31:25];
    imm = {{20{word[31]}}, word[31:20]};
    ok  = 1'b1;
    val = '0;
    if (opc == cpu_pkg::OPC_OP_IMM && f3 == 3'd0) begin
      val = a + imm;
    end else if (opc == cpu_pkg::OPC_OP && f7 == F7_MUL && f3 == 3'd0) begin
      val = a * b;
    end else if (opc == cpu_pkg::OPC_OP && f7 == F7_ALT && f3 == 3'd0) begin
      val = a - b;
    end else if (opc == cpu_pkg::OPC_OP && f7 == F7_BASE) begin
      case (f3)
        3'd0:    val = a + b;
        3'd1:    val = a << b[4:0];
        3'd2:    val = {31'b0, $signed(a) < $signed(b)};
        3'd4:    val = a ^ b;
        3'd5:    val = a >> b[4:0];
        3'd6:    val = a | b;
        3'd7:    val = a & b;
        default: ok = 1'b0;
      endcase
    end else begin
      ok = 1'b0;
    end
    if (rd == 5'd0) begin
      ok = 1'b0;
    end
    return {ok, rd, val};
  endfunction

  function automatic string section_name(input int idx);
    return (idx < dir_len) ? "directed" : "random";
  endfunction

  task automatic build_program();
    push_addi(1, 0, -5);
    push_addi(2, 0, 100);
    push_addi(3, 0, -2048);
    push_addi(4, 0, 7);
    push_op(F7_BASE, 3'd0, 5, 1, 2);
    push_op(F7_ALT, 3'd0, 6, 1, 2);
    push_op(F7_BASE, 3'd7, 7, 2, 3);
    push_op(F7_BASE, 3'd6, 8, 1, 4);
    push_op(F7_BASE, 3'd4, 9, 1, 2);
    push_op(F7_BASE, 3'd2, 10, 1, 2);
    push_op(F7_BASE, 3'd2, 11, 2, 1);
    push_op(F7_BASE, 3'd1, 12, 1, 4);
    push_op(F7_BASE, 3'd5, 13, 1, 4);
    // Dependent chain on x14
    push_addi(14, 14, -1);
    push_op(F7_BASE, 3'd0, 14, 14, 14);
    push_op(F7_ALT, 3'd0, 14, 14, 1);
    // Multiplies interleaved with ALU work
    push_op(F7_MUL, 3'd0, 15, 1, 2);
    push_op(F7_MUL, 3'd0, 16, 15, 4);
    push_op(F7_MUL, 3'd0, 17, 2, 2);
    push_op(F7_BASE, 3'd0, 18, 4, 4);
    push_op(F7_MUL, 3'd0, 19, 3, 1);
    push_op(F7_BASE, 3'd4, 20, 18, 17);
    // x0 targets, then a load, a bad sub variant and mulh
    push_addi(0, 1, 5);
    push_op(F7_BASE, 3'd0, 0, 1, 2);
    prog.push_back(i_type_word(7'b0000011, 3'b010, 5'd21, 5'd0, 12'd0));
    push_op(F7_ALT, 3'd1, 22, 1, 2);
    push_op(F7_MUL, 3'd1, 23, 1, 2);
    push_addi(24, 5, -1);
    dir_len = prog.size();
    for (int i = 0; i < RAND_LEN; i++) begin
      prog.push_back(random_word());
    end
  endtask

  // Sequential model pass over the whole program
  task automatic build_expected();
    logic [31:0] shadow [32];
    logic [37:0] res;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    for (int i = 0; i < prog.size(); i++) begin
      res = reference_write(prog[i], shadow[prog[i][19:15]], shadow[prog[i][24:20]]);
      if (res[37]) begin
        shadow[res[36:32]] = res[31:0];
        exp_reg.push_back(res[36:32]);
        exp_val.push_back(res[31:0]);
        exp_idx.push_back(i);
      end
    end
  endtask

  task automatic check_idle(input string when);
    assert (rd_req_valid_o === 1'b0 && retire_valid_o === 1'b0)
      else report_failure($sformatf("Fail %s req/retire valid expected 00 actual %b%b",
                                    when, rd_req_valid_o, retire_valid_o));
  endtask

  // Memory answers each read after 1 to 3 cycles
  initial begin : memory_model
    logic [ADDR_WIDTH-1:0] addr;
    int unsigned           delay;
    int                    idx;
    forever begin
      @(negedge clk_i);
      if (rst_i && rd_req_valid_o) begin
        addr = req_address_o;
        idx  = int'(addr >> 2);
        if (idx >= prog.size()) begin
          fetched_all = 1'b1;
        end
        delay = 1 + ($urandom % 3);
        repeat (delay) @(posedge clk_i);
        #2;
        mem_data_valid_i = 1'b1;
        mem_data_i       = (idx < prog.size()) ? prog[idx] : NOP_WORD;
        @(posedge clk_i);
        #2;
        mem_data_valid_i = 1'b0;
      end
    end
  end

  always @(negedge clk_i) begin : compare
    int found;
    found = -1;
    if (rst_i === 1'b1 && retire_valid_o === 1'b1) begin
      for (int i = 0; i < exp_reg.size(); i++) begin
        if (found < 0 && exp_reg[i] == retire_reg_o) begin
          found = i;
        end
      end
      assert (found >= 0)
        else report_failure($sformatf("Register x%0d retired with no write pending",
                                      retire_reg_o));
      if (found >= 0) begin
        assert (retire_data_o == exp_val[found])
          else report_failure($sformatf("Fail %s x%0d expected %h actual %h",
                                        section_name(exp_idx[found]), retire_reg_o,
                                        exp_val[found], retire_data_o));
        exp_reg.delete(found);
        exp_val.delete(found);
        exp_idx.delete(found);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    assert (cycle_limit == 0 || cycles <= cycle_limit)
      else report_failure($sformatf("Timeout with %0d expected writes never retired",
                                    exp_reg.size()));
  end

  initial begin
    rst_i            = 1'b0;
    mem_data_valid_i = 1'b0;
    mem_data_i       = '0;
    fetched_all      = 1'b0;
    cycles           = 0;
    cycle_limit      = 0;
    drain_end        = 0;
    void'($urandom(SEED));
    build_program();
    build_expected();
    cycle_limit = prog.size() * (4 + MUL_DEPTH + 2) + 100;
    repeat (3) begin
      @(posedge clk_i);
      #2;
      check_idle("reset");
    end
    rst_i = 1'b1;
    @(negedge clk_i);
    check_idle("first cycle after reset");
    while (!rd_req_valid_o) @(negedge clk_i);
    assert (req_address_o == '0)
      else report_failure($sformatf("Fail first request address expected 0 actual %h",
                                    req_address_o));
    while (!fetched_all) @(negedge clk_i);
    // Fetch only runs past the program once its last instruction has issued
    drain_end = cycles + MUL_DEPTH + 6;
    while (exp_reg.size() != 0 && cycles < drain_end) @(negedge clk_i);
    // Window for any stray retire after the last expected one
    repeat (MUL_DEPTH + 6) @(negedge clk_i);
    if (exp_reg.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_failure($sformatf("%0d expected writes left at the end", exp_reg.size()));
    end
  end

endmodule

/* compile.f */
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/alu_stage.sv
rtl/mul_pipe.sv
rtl/wb_arbiter.sv
rtl/cpu_core.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
  -f compile.f -o cpu_sim > build.log 2>&1 \
  && ./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "^Testbench passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
